// File: list.f
+incdir+src
src/btb_pkg.sv
src/btb_wr_if.sv
src/btb_f1_if.sv
src/btb_sram_bank.sv
src/btb_write_ctrl.sv
src/btb_valid_array.sv
src/btb_hit_select.sv
src/btb_mem_top.sv
verif/btb_mem_tb.sv

// File: run.sh
#!/bin/sh
# build the btb storage testbench with verilator, run it, scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module btb_mem_tb -o btb_sim
./obj_dir/btb_sim > sim.log
cat sim.log
if grep -q ">>> FAIL" sim.log; then
   exit 1
fi
exit 0

// File: src/btb_f1_if.sv
// btb f1 stage control and address interface
`timescale 1ns/1ps

interface btb_f1_if;

   // registered read and write strobes
   logic                  rden_f1;
   logic                  wren_f1;
   // valid flag of the written entry
   logic                  datav_f1;
   // registered rw_addr0, write address and current row
   btb_pkg::btb_addr_u    addr0_f1;
   // registered rw_addr1, p1 row and fetch start
   btb_pkg::btb_addr_u    addr1_f1;

   // pipeline register side
   modport src (output rden_f1, wren_f1, datav_f1, addr0_f1, addr1_f1);

   // valid array and hit select side
   modport sink (input rden_f1, wren_f1, datav_f1, addr0_f1, addr1_f1);

endinterface

// File: src/btb_hit_select.sv
// btb f1 bank swap, tag compare, offset spread and virtual bank rotation
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_hit_select (
   btb_f1_if.sink                                    f1,
   input  logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0]    rd_row0,
   input  logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0]    rd_row1,
   input  logic [`BTB_LANES-1:0]                     rd0_valid,
   input  logic [`BTB_LANES-1:0]                     rd1_valid,
   input  logic [`BTB_TAG_W-1:0]                     rd_tag0,
   input  logic [`BTB_TAG_W-1:0]                     rd_tag1,
   output logic [`BTB_DWIDTH-1:0]                    vbank0_rd_data,
   output logic [`BTB_DWIDTH-1:0]                    vbank1_rd_data,
   output logic [`BTB_DWIDTH-1:0]                    vbank2_rd_data,
   output logic [`BTB_DWIDTH-1:0]                    vbank3_rd_data,
   output logic [3:0]                                wayhit,
   output logic [3:0]                                wayhit_p1
);

   // row 0 is the current fetch row, row 1 the p1 row
   logic [1:0][`BTB_LANES-1:0][`BTB_DWIDTH-1:0]   ent;
   logic [1:0][`BTB_TAG_W-1:0]                    tag;
   logic [1:0][`BTB_LANES-1:0]                    lane_hit;
   // slots per row: e0, o0, e1, o1
   logic [1:0][`BTB_LANES-1:0]                    slot_hit;
   logic [1:0][`BTB_LANES-1:0][`BTB_DWIDTH-1:0]   slot_data;
   // seven candidates, four current then three p1
   logic [6:0][`BTB_DWIDTH-1:0]                   seq;
   logic [3:0][`BTB_DWIDTH-1:0]                   vbank;
   logic [1:0]                                    fetch_start;

   // ------------------------------
   // bank swap
   // ------------------------------

   // bank bit of addr1 says which physical bank holds the current row
   always_comb begin
      for (int k = 0; k < `BTB_LANES; k++) begin
         if (f1.addr1_f1.fields.bank) begin
            ent[0][k] = rd_row1[k];
            ent[1][k] = rd_row0[k];
            ent[0][k][`BTB_BV] = rd1_valid[k];
            ent[1][k][`BTB_BV] = rd0_valid[k];
         end else begin
            ent[0][k] = rd_row0[k];
            ent[1][k] = rd_row1[k];
            ent[0][k][`BTB_BV] = rd0_valid[k];
            ent[1][k][`BTB_BV] = rd1_valid[k];
         end
      end
   end

   // current row against tag0, p1 row against tag1
   assign tag[0] = rd_tag0;
   assign tag[1] = rd_tag1;

   // ------------------------------
   // tag compare and offset spread
   // ------------------------------

   always_comb begin
      logic odd;
      int   slot;
      slot_hit  = '0;
      slot_data = '0;
      for (int r = 0; r < 2; r++) begin
         for (int k = 0; k < `BTB_LANES; k++) begin
            // valid entry, tag match, read in flight
            lane_hit[r][k] = f1.rden_f1 & ent[r][k][`BTB_BV] &
                             (ent[r][k][`BTB_TAG_LSB +: `BTB_TAG_W] == tag[r]);
            // branch in the upper halfword of the half goes odd
            odd  = ent[r][k][`BTB_BOFF] ^ ent[r][k][`BTB_PC4];
            // lane k is half k/2, slot 2*half + odd
            slot = 2 * (k / 2) + (odd ? 1 : 0);
            if (lane_hit[r][k]) begin
               slot_hit[r][slot]  = 1'b1;
               // both ways hitting the same slot are or'ed
               slot_data[r][slot] = slot_data[r][slot] | ent[r][k];
            end
         end
      end
   end

   assign wayhit    = slot_hit[0];
   assign wayhit_p1 = slot_hit[1];

   // ------------------------------
   // virtual bank rotation
   // ------------------------------

   // fetch start is the {half, way} pair of the fetch address
   assign fetch_start = {f1.addr1_f1.fields.half, f1.addr1_f1.fields.way};

   // p1 o1 never reachable, start 3 ends at p1 e1
   assign seq = {slot_data[1][2:0], slot_data[0]};

   always_comb begin
      for (int k = 0; k < 4; k++) begin
         vbank[k] = seq[int'(fetch_start) + k];
      end
   end

   assign vbank0_rd_data = vbank[0];
   assign vbank1_rd_data = vbank[1];
   assign vbank2_rd_data = vbank[2];
   assign vbank3_rd_data = vbank[3];

endmodule

// File: src/btb_mem_top.sv
// btb storage top level, write decode, two sram banks, valid array and hit select
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_mem_top (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wren,
   input  logic                     rden,
   input  logic [`BTB_ADDR_W-1:0]   rw_addr0,
   input  logic [`BTB_ADDR_W-1:0]   rw_addr1,
   input  logic [`BTB_DWIDTH-1:0]   wr_data,
   input  logic [`BTB_TAG_W-1:0]    rd_tag0,
   input  logic [`BTB_TAG_W-1:0]    rd_tag1,
   output logic [`BTB_DWIDTH-1:0]   vbank0_rd_data,
   output logic [`BTB_DWIDTH-1:0]   vbank1_rd_data,
   output logic [`BTB_DWIDTH-1:0]   vbank2_rd_data,
   output logic [`BTB_DWIDTH-1:0]   vbank3_rd_data,
   output logic [3:0]               wayhit,
   output logic [3:0]               wayhit_p1
);

   // ------------------------------
   // internal buses
   // ------------------------------

   // write strobes and row selects to the banks
   btb_wr_if wr_bus ();
   // f1 control and addresses
   btb_f1_if f1_bus ();

   // raw rows out of each physical bank
   logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0] rd_row0;
   logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0] rd_row1;
   // lane valids for each bank's row
   logic [`BTB_LANES-1:0]                  rd0_valid;
   logic [`BTB_LANES-1:0]                  rd1_valid;

   // ------------------------------
   // instances
   // ------------------------------

   btb_write_ctrl btb_write_ctrl_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wren     (wren),
      .rden     (rden),
      .rw_addr0 (rw_addr0),
      .rw_addr1 (rw_addr1),
      .wr_data  (wr_data),
      .wr       (wr_bus.ctrl),
      .f1       (f1_bus.src)
   );

   // bank 0 holds the even 8 byte blocks
   btb_sram_bank #(.BANK(0)) btb_sram_bank0_i (
      .clk    (clk),
      .wr     (wr_bus.bank),
      .rd_row (rd_row0)
   );

   btb_sram_bank #(.BANK(1)) btb_sram_bank1_i (
      .clk    (clk),
      .wr     (wr_bus.bank),
      .rd_row (rd_row1)
   );

   btb_valid_array btb_valid_array_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .f1        (f1_bus.sink),
      .rd0_valid (rd0_valid),
      .rd1_valid (rd1_valid)
   );

   btb_hit_select btb_hit_select_i (
      .f1             (f1_bus.sink),
      .rd_row0        (rd_row0),
      .rd_row1        (rd_row1),
      .rd0_valid      (rd0_valid),
      .rd1_valid      (rd1_valid),
      .rd_tag0        (rd_tag0),
      .rd_tag1        (rd_tag1),
      .vbank0_rd_data (vbank0_rd_data),
      .vbank1_rd_data (vbank1_rd_data),
      .vbank2_rd_data (vbank2_rd_data),
      .vbank3_rd_data (vbank3_rd_data),
      .wayhit         (wayhit),
      .wayhit_p1      (wayhit_p1)
   );

endmodule

// File: src/btb_pkg.sv
// btb package with the entry address union
package btb_pkg;

`include "btb_settings.svh"

   // entry address, bits 5..1 of the fetch address
   // flat view indexes the valid array directly
   // fields view splits it for the banks and lanes
   typedef union packed {
      logic [`BTB_ADDR_W-1:0] flat;
      struct packed {
         // row inside a bank, addr bits 5:4
         logic [`BTB_INDEX_W-1:0] index;
         // physical bank, addr bit 3
         logic                    bank;
         // half of the row, addr bit 2
         logic                    half;
         // way inside the half, addr bit 1
         logic                    way;
      } fields;
   } btb_addr_u;

endpackage

// File: src/btb_settings.svh
// btb widths, entry bit positions and array sizes
`ifndef BTB_SETTINGS_SVH
`define BTB_SETTINGS_SVH

// ------------------------------
// entry layout
// ------------------------------

// one btb entry, target + tag + flags
`define BTB_DWIDTH   34
// tag field sits in the top bits
`define BTB_TAG_W    9
`define BTB_TAG_LSB  25
// flag bits inside an entry
`define BTB_PC4      4
`define BTB_BOFF     3
`define BTB_BV       0

// ------------------------------
// array shape
// ------------------------------

// row index per physical bank
`define BTB_INDEX_W  2
`define BTB_ROWS     4
// one valid bit per entry, 2 banks x 4 rows x 4 lanes
`define BTB_VALID_N  32
// entry address, fetch address bits 5..1
`define BTB_ADDR_W   5
// two halves x two ways per row
`define BTB_LANES    4

`endif

// File: src/btb_sram_bank.sv
// btb physical sram bank, four rows of four lanes
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_sram_bank #(
   parameter int BANK = 0
) (
   input  logic                                      clk,
   btb_wr_if.bank                                    wr,
   output logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0]    rd_row
);

   // ------------------------------
   // storage
   // ------------------------------

   // row array, all four lanes side by side
   logic [`BTB_LANES-1:0][`BTB_DWIDTH-1:0] mem [`BTB_ROWS];

   // this bank's row select
   logic [`BTB_INDEX_W-1:0]                row_sel;

   assign row_sel = wr.row_index[BANK];

   // ------------------------------
   // write and read port
   // ------------------------------

   always_ff @(posedge clk) begin
      // lane masked write, only this bank's strobe
      if (wr.wren_bank[BANK]) begin
         for (int k = 0; k < `BTB_LANES; k++) begin
            if (wr.lane_en[k]) begin
               mem[row_sel][k] <= wr.wr_data;
            end
         end
      end
      // read every cycle, row shows up in f1
      // old contents on a same cycle write
      rd_row <= mem[row_sel];
   end

endmodule

// File: src/btb_valid_array.sv
// btb valid bit array, f1 update and per lane read valids
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_valid_array (
   input  logic                     clk,
   input  logic                     rst_n,
   btb_f1_if.sink                   f1,
   output logic [`BTB_LANES-1:0]    rd0_valid,
   output logic [`BTB_LANES-1:0]    rd1_valid
);

   // one bit per entry, indexed by the flat address
   logic [`BTB_VALID_N-1:0] valid_q;

   // ------------------------------
   // update in f1
   // ------------------------------

   // set on a valid write, clear on an invalidate
   // a write in t lands here at the end of t+1
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (f1.wren_f1) begin
         valid_q[f1.addr0_f1.flat] <= f1.datav_f1;
      end
   end

   // ------------------------------
   // read valids
   // ------------------------------

   // bank 0 row from addr0, bank 1 row from addr1
   // lane k picks {index, bank, k}
   for (genvar k = 0; k < `BTB_LANES; k++) begin : g_lane
      assign rd0_valid[k] = f1.rden_f1 &
                            valid_q[{f1.addr0_f1.fields.index, 1'b0, 2'(k)}];
      assign rd1_valid[k] = f1.rden_f1 &
                            valid_q[{f1.addr1_f1.fields.index, 1'b1, 2'(k)}];
   end

endmodule

// File: src/btb_wr_if.sv
// btb write interface to the sram banks
`timescale 1ns/1ps
`include "btb_settings.svh"

interface btb_wr_if;

   // per physical bank write strobe
   logic [1:0]                        wren_bank;
   // lane order h0w0, h0w1, h1w0, h1w1
   logic [`BTB_LANES-1:0]             lane_en;
   // same entry goes to every enabled lane
   logic [`BTB_DWIDTH-1:0]            wr_data;
   // one row index per bank
   logic [1:0][`BTB_INDEX_W-1:0]      row_index;

   // write decode side
   modport ctrl (output wren_bank, lane_en, wr_data, row_index);

   // sram bank side
   modport bank (input wren_bank, lane_en, wr_data, row_index);

endinterface

// File: src/btb_write_ctrl.sv
// btb bank and lane write decode with the f1 pipeline registers
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_write_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wren,
   input  logic                     rden,
   input  btb_pkg::btb_addr_u       rw_addr0,
   input  btb_pkg::btb_addr_u       rw_addr1,
   input  logic [`BTB_DWIDTH-1:0]   wr_data,
   btb_wr_if.ctrl                   wr,
   btb_f1_if.src                    f1
);

   // lane number of the write, {half, way}
   logic [1:0] wr_lane;

   assign wr_lane = {rw_addr0.fields.half, rw_addr0.fields.way};

   // ------------------------------
   // bank and lane decode
   // ------------------------------

   // sram only written when the entry is being validated
   // an invalidate just clears the valid bit in f1
   assign wr.wren_bank[1] = wren &  rw_addr0.fields.bank & wr_data[`BTB_BV];
   assign wr.wren_bank[0] = wren & ~rw_addr0.fields.bank & wr_data[`BTB_BV];

   // one hot lane enable
   assign wr.lane_en = {`BTB_LANES{wren}} & (`BTB_LANES'(1) << wr_lane);

   // both banks see the same entry
   assign wr.wr_data = wr_data;

   // bank 0 row always from rw_addr0
   assign wr.row_index[0] = rw_addr0.fields.index;
   // bank 1 reads the p1 row from rw_addr1
   // on a write the row comes from rw_addr0 like the valid bit does
   assign wr.row_index[1] = wren ? rw_addr0.fields.index : rw_addr1.fields.index;

   // ------------------------------
   // f1 registers
   // ------------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         f1.rden_f1  <= 1'b0;
         f1.wren_f1  <= 1'b0;
         f1.datav_f1 <= 1'b0;
         f1.addr0_f1 <= '0;
         f1.addr1_f1 <= '0;
      end else begin
         f1.rden_f1  <= rden;
         f1.wren_f1  <= wren;
         // valid flag of the write, drives the f1 valid update
         f1.datav_f1 <= wr_data[`BTB_BV];
         f1.addr0_f1 <= rw_addr0;
         f1.addr1_f1 <= rw_addr1;
      end
   end

endmodule

// File: verif/btb_mem_tb.sv
// btb storage testbench, clock, reset, lfsr stimulus, reference model and output checks
`timescale 1ns/1ps
`include "btb_settings.svh"

module btb_mem_tb;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          wren;
   logic                          rden;
   logic [`BTB_ADDR_W-1:0]        rw_addr0;
   logic [`BTB_ADDR_W-1:0]        rw_addr1;
   logic [`BTB_DWIDTH-1:0]        wr_data;
   logic [`BTB_TAG_W-1:0]         rd_tag0;
   logic [`BTB_TAG_W-1:0]         rd_tag1;
   logic [3:0][`BTB_DWIDTH-1:0]   vbank;
   logic [3:0]                    wayhit;
   logic [3:0]                    wayhit_p1;
   // model holds one entry and one valid bit per flat address
   logic [`BTB_DWIDTH-1:0]        mdl_data [`BTB_VALID_N];
   logic                          mdl_valid [`BTB_VALID_N];
   logic [3:0][`BTB_DWIDTH-1:0]   exp_vbank;
   logic [1:0][3:0]               exp_hit;
   logic [31:0]                   lfsr_q = 32'hca3a;
   int                            errors = 0;
   int                            timeouts = 0;
   int                            checks = 0;

   always #5 clk = ~clk;

   btb_mem_top btb_mem_top_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .wren           (wren),
      .rden           (rden),
      .rw_addr0       (rw_addr0),
      .rw_addr1       (rw_addr1),
      .wr_data        (wr_data),
      .rd_tag0        (rd_tag0),
      .rd_tag1        (rd_tag1),
      .vbank0_rd_data (vbank[0]),
      .vbank1_rd_data (vbank[1]),
      .vbank2_rd_data (vbank[2]),
      .vbank3_rd_data (vbank[3]),
      .wayhit         (wayhit),
      .wayhit_p1      (wayhit_p1)
   );

   // ------------------------------
   // lfsr and stimulus helpers
   // ------------------------------

   // fibonacci taps 32, 22, 2, 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], next_bit()};
      end
      return r;
   endfunction

   function automatic logic [`BTB_TAG_W-1:0] rand_tag();
      logic [31:0] r;
      r = rand_bits(`BTB_TAG_W);
      return r[`BTB_TAG_W-1:0];
   endfunction

   // random target and flags around a given tag and valid bit
   function automatic logic [`BTB_DWIDTH-1:0] make_entry(input logic [`BTB_TAG_W-1:0] tag,
                                                         input logic bv);
      logic [31:0]            lo;
      logic [31:0]            hi;
      logic [`BTB_DWIDTH-1:0] e;
      lo = rand_bits(32);
      hi = rand_bits(`BTB_DWIDTH - 32);
      e = {hi[`BTB_DWIDTH-33:0], lo};
      e[`BTB_TAG_LSB +: `BTB_TAG_W] = tag;
      e[`BTB_BV] = bv;
      return e;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------

   function automatic void compute_expected(input logic [`BTB_ADDR_W-1:0] a0,
                                            input logic [`BTB_ADDR_W-1:0] a1,
                                            input logic [`BTB_TAG_W-1:0] t0,
                                            input logic [`BTB_TAG_W-1:0] t1);
      logic [1:0][3:0][`BTB_DWIDTH-1:0] sd;
      logic [6:0][`BTB_DWIDTH-1:0]      cand;
      logic                             rb;
      logic [1:0]                       ri;
      logic [`BTB_TAG_W-1:0]            rt;
      logic [`BTB_ADDR_W-1:0]           fa;
      logic [`BTB_DWIDTH-1:0]           e;
      int                               slot;
      sd = '0;
      exp_hit = '0;
      for (int r = 0; r < 2; r++) begin
         // current row in the bank named by addr1 and p1 in the other
         rb = (r == 0) ? a1[2] : ~a1[2];
         // bank 0 indexed by addr0 and bank 1 by addr1
         ri = rb ? a1[4:3] : a0[4:3];
         rt = (r == 0) ? t0 : t1;
         for (int k = 0; k < 4; k++) begin
            fa = {ri, rb, 2'(k)};
            e = mdl_data[fa];
            e[`BTB_BV] = mdl_valid[fa];
            if (mdl_valid[fa] && e[`BTB_TAG_LSB +: `BTB_TAG_W] == rt) begin
               // even slot of the half or odd when boff and pc4 differ
               slot = 2 * (k / 2);
               if (e[`BTB_BOFF] != e[`BTB_PC4]) begin
                  slot = slot + 1;
               end
               exp_hit[r][slot] = 1'b1;
               sd[r][slot] = sd[r][slot] | e;
            end
         end
      end
      // current e0 o0 e1 o1 followed by p1 e0 o0 e1
      for (int j = 0; j < 4; j++) begin
         cand[j] = sd[0][j];
      end
      for (int j = 0; j < 3; j++) begin
         cand[4 + j] = sd[1][j];
      end
      for (int k = 0; k < 4; k++) begin
         exp_vbank[k] = cand[int'(a1[1:0]) + k];
      end
   endfunction

   // ------------------------------
   // bus tasks
   // ------------------------------

   task automatic write_entry(input logic [`BTB_ADDR_W-1:0] a,
                              input logic [`BTB_DWIDTH-1:0] d);
      @(posedge clk);
      wren     <= 1'b1;
      rw_addr0 <= a;
      wr_data  <= d;
      @(posedge clk);
      wren <= 1'b0;
      // sram keeps old data on an invalidate
      if (d[`BTB_BV]) begin
         mdl_data[a] = d;
      end
      mdl_valid[a] = d[`BTB_BV];
   endtask

   // issue in t with tags and checks in t+1
   task automatic read_check(input logic [`BTB_ADDR_W-1:0] a0,
                             input logic [`BTB_ADDR_W-1:0] a1,
                             input logic [`BTB_TAG_W-1:0] t0,
                             input logic [`BTB_TAG_W-1:0] t1);
      @(posedge clk);
      rden     <= 1'b1;
      rw_addr0 <= a0;
      rw_addr1 <= a1;
      @(posedge clk);
      rden    <= 1'b0;
      rd_tag0 <= t0;
      rd_tag1 <= t1;
      @(negedge clk);
      compute_expected(a0, a1, t0, t1);
      checks++;
      assert (wayhit == exp_hit[0] && wayhit_p1 == exp_hit[1]) else begin
         $display("FAIL %0t: wayhit %b/%b expected %b/%b", $time, wayhit, wayhit_p1,
                  exp_hit[0], exp_hit[1]);
         errors++;
      end
      for (int k = 0; k < 4; k++) begin
         assert (vbank[k] == exp_vbank[k]) else begin
            $display("FAIL %0t: vbank%0d got %h expected %h", $time, k, vbank[k],
                     exp_vbank[k]);
            errors++;
         end
      end
   endtask

   // outputs must settle to zero once out of reset
   task automatic wait_idle(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      while ((wayhit !== '0 || wayhit_p1 !== '0 || vbank !== '0) && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (wayhit !== '0 || wayhit_p1 !== '0 || vbank !== '0) begin
         $display("timeout: outputs still not zero %0d cycles after reset", limit);
         timeouts++;
      end
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------

   initial begin
      logic [31:0]             r;
      logic [`BTB_ADDR_W-1:0]  a;
      logic [`BTB_TAG_W-1:0]   tg;
      logic [`BTB_TAG_W-1:0]   row_tag [4];
      rst_n    = 1'b0;
      wren     = 1'b0;
      rden     = 1'b0;
      rw_addr0 = '0;
      rw_addr1 = '0;
      wr_data  = '0;
      rd_tag0  = '0;
      rd_tag1  = '0;
      for (int i = 0; i < `BTB_VALID_N; i++) begin
         mdl_data[i]  = '0;
         mdl_valid[i] = 1'b0;
      end
      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
      end
      rst_n <= 1'b1;
      wait_idle(20);
      // nothing may hit in the empty array
      for (int i = 0; i < 8; i++) begin
         r = rand_bits(10);
         read_check(r[4:0], r[9:5], rand_tag(), rand_tag());
      end
      // write and read back then again with one tag bit off
      for (int i = 0; i < 12; i++) begin
         r = rand_bits(5);
         a = r[4:0];
         tg = rand_tag();
         write_entry(a, make_entry(tg, 1'b1));
         r = rand_bits(7);
         read_check(a, {a[4:3], r[2:0]}, tg, tg);
         tg = tg ^ (`BTB_TAG_W'(1) << (int'(r[6:3]) % `BTB_TAG_W));
         read_check(a, {a[4:3], r[2:0]}, tg, tg);
      end
      // invalidate and restore one entry
      a = {2'd3, 1'b1, 1'b0, 1'b1};
      tg = rand_tag();
      write_entry(a, make_entry(tg, 1'b1));
      read_check(a, a, tg, tg);
      write_entry(a, make_entry(tg, 1'b0));
      read_check(a, a, tg, tg);
      write_entry(a, make_entry(tg, 1'b1));
      read_check(a, a, tg, tg);
      // fill rows 1 and 2 in both banks and sweep swap and fetch start
      for (int ri = 1; ri < 3; ri++) begin
         row_tag[ri] = rand_tag();
         for (int ln = 0; ln < 8; ln++) begin
            write_entry({2'(ri), 3'(ln)}, make_entry(row_tag[ri], 1'b1));
         end
      end
      for (int bk = 0; bk < 2; bk++) begin
         for (int s = 0; s < 4; s++) begin
            r = rand_bits(3);
            if (bk == 1) begin
               read_check({2'd1, r[2:0]}, {2'd2, 1'b1, 2'(s)}, row_tag[2], row_tag[1]);
            end else begin
               read_check({2'd1, r[2:0]}, {2'd2, 1'b0, 2'(s)}, row_tag[1], row_tag[2]);
            end
         end
      end
      $display("reads checked %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
